// ==== build.f ====
+incdir+testbench
hw/lsu_bus_pkg.sv
hw/lsu_isa_pkg.sv
hw/lsu_pending_if.sv
hw/lsu_issue.sv
hw/lsu_pending_queue.sv
hw/lsu_writeback.sv
hw/lsu_top.sv
testbench/tb_lsu.sv

// ==== hw/lsu_bus_pkg.sv ====
package lsu_bus_pkg;

    // ================================================
    // memory side widths
    // ================================================
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;   // byte address
    typedef logic [DATA_W-1:0] data_t;   // memory word, also register value
    typedef logic [STRB_W-1:0] strb_t;   // one enable per byte lane

    // mem_req_opcode encoding
    localparam logic BUS_READ  = 1'b0;
    localparam logic BUS_WRITE = 1'b1;

    // ================================================
    // pending result queue
    // ================================================
    localparam int PEND_DEPTH = 4;                    // max reads in flight
    localparam int PEND_PTR_W = $clog2(PEND_DEPTH);

endpackage

// ==== hw/lsu_isa_pkg.sv ====
package lsu_isa_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  tag_t;      // returned with the register write
    typedef logic [2:0]  funct3_t;

    // ================================================
    // major opcodes, instruction bits [6:2]
    // ================================================
    localparam logic [4:0] OPC_LOAD  = 5'b00000;
    localparam logic [4:0] OPC_STORE = 5'b01000;
    localparam logic [4:0] OPC_AMO   = 5'b01011;

    // access width and sign, stores share the low three codes
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // ================================================
    // atomic funct5, instruction bits [31:27]
    // ================================================
    localparam logic [4:0] AMO_LR   = 5'b00010;
    localparam logic [4:0] AMO_SC   = 5'b00011;
    localparam logic [4:0] AMO_SWAP = 5'b00001;
    localparam logic [4:0] AMO_ADD  = 5'b00000;
    localparam logic [4:0] AMO_XOR  = 5'b00100;
    localparam logic [4:0] AMO_AND  = 5'b01100;
    localparam logic [4:0] AMO_OR   = 5'b01000;
    localparam logic [4:0] AMO_MIN  = 5'b10000;
    localparam logic [4:0] AMO_MAX  = 5'b10100;
    localparam logic [4:0] AMO_MINU = 5'b11000;
    localparam logic [4:0] AMO_MAXU = 5'b11100;

    // what a queued entry waits for
    typedef enum logic [1:0] {
        LOAD,
        AMO_RMW,     // read half of an atomic
        LR,
        SC_DONE      // no ack, result known at issue
    } pend_kind_t;

    typedef enum logic [1:0] {
        IDLE,
        AMO_WAIT,
        AMO_WRITE
    } issue_state_t;

endpackage

// ==== hw/lsu_issue.sv ====
`timescale 1ns/1ps

module lsu_issue
    import lsu_bus_pkg::*;
    import lsu_isa_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    input  logic          instruction_vld,
    output logic          instruction_rdy,
    input  inst_t         instruction_pld,
    input  tag_t          inst_tag,
    input  reg_idx_t      inst_rd_idx,
    input  logic          inst_rd_en,
    input  data_t         rs1_val,
    input  data_t         rs2_val,
    input  data_t         inst_imm,

    output logic          mem_req_vld,
    input  logic          mem_req_rdy,
    output addr_t         mem_req_addr,
    output data_t         mem_req_data,
    output strb_t         mem_req_strb,
    output logic          mem_req_opcode,

    input  logic          amo_old_vld,
    input  data_t         amo_old_data,

    lsu_pending_if.source enq
);

    logic [4:0]   opcode;
    logic [4:0]   funct5;
    funct3_t      funct3;
    logic         is_load;
    logic         is_store;
    logic         is_lr;
    logic         is_sc;
    logic         is_rmw;
    addr_t        addr;
    logic [1:0]   offset;
    logic         inst_fire;
    issue_state_t state;
    issue_state_t state_nxt;
    data_t        old_data;
    data_t        amo_result;
    addr_t        resv_addr;
    logic         resv_vld;
    logic         sc_ok;

    // ================================================
    // decode and address
    // ================================================
    assign opcode   = instruction_pld[6:2];
    assign funct3   = instruction_pld[14:12];
    assign funct5   = instruction_pld[31:27];
    assign is_load  = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);
    assign is_lr    = (opcode == OPC_AMO) && (funct5 == AMO_LR);
    assign is_sc    = (opcode == OPC_AMO) && (funct5 == AMO_SC);
    assign is_rmw   = (opcode == OPC_AMO) && !is_lr && !is_sc;

    assign addr      = rs1_val + inst_imm;
    assign offset    = addr[1:0];
    assign inst_fire = instruction_vld && instruction_rdy;
    assign sc_ok     = resv_vld && (resv_addr == addr);

    assign mem_req_addr = addr;   // held by the driver until rdy

    // ================================================
    // handshakes and amo sequencing
    // ================================================
    always_comb begin
        instruction_rdy = 1'b0;
        mem_req_vld     = 1'b0;
        mem_req_opcode  = BUS_READ;
        enq.vld         = 1'b0;
        state_nxt       = state;
        case (state)
            IDLE: begin
                if (is_store) begin
                    mem_req_vld     = instruction_vld;
                    mem_req_opcode  = BUS_WRITE;
                    instruction_rdy = mem_req_rdy;
                end else if (is_load || is_lr || is_sc || is_rmw) begin
                    // request and queue entry go together or not at all
                    mem_req_vld     = instruction_vld && enq.rdy;
                    mem_req_opcode  = is_sc ? BUS_WRITE : BUS_READ;
                    enq.vld         = instruction_vld && mem_req_rdy;
                    instruction_rdy = mem_req_rdy && enq.rdy && !is_rmw;
                    if (is_rmw && instruction_vld && mem_req_rdy && enq.rdy) begin
                        state_nxt = AMO_WAIT;
                    end
                end else begin
                    instruction_rdy = 1'b1;   // not a memory op, dropped
                end
            end
            AMO_WAIT: begin
                if (amo_old_vld) begin
                    state_nxt = AMO_WRITE;
                end
            end
            AMO_WRITE: begin
                mem_req_vld     = 1'b1;
                mem_req_opcode  = BUS_WRITE;
                instruction_rdy = mem_req_rdy;   // end of the atomic
                if (mem_req_rdy) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == AMO_WAIT && amo_old_vld) begin
            old_data <= amo_old_data;
        end
    end

    always_comb begin
        case (funct5)
            AMO_SWAP: amo_result = rs2_val;
            AMO_ADD:  amo_result = old_data + rs2_val;
            AMO_XOR:  amo_result = old_data ^ rs2_val;
            AMO_AND:  amo_result = old_data & rs2_val;
            AMO_OR:   amo_result = old_data | rs2_val;
            AMO_MIN:  amo_result = ($signed(rs2_val) < $signed(old_data)) ? rs2_val : old_data;
            AMO_MAX:  amo_result = ($signed(rs2_val) < $signed(old_data)) ? old_data : rs2_val;
            AMO_MINU: amo_result = (rs2_val < old_data) ? rs2_val : old_data;
            AMO_MAXU: amo_result = (rs2_val < old_data) ? old_data : rs2_val;
            default:  amo_result = rs2_val;
        endcase
    end

    // ================================================
    // write data and strobes
    // ================================================
    always_comb begin
        mem_req_data = rs2_val << {offset, 3'b000};
        case (funct3)
            F3_LB, F3_LBU: mem_req_strb = 4'b0001 << offset;
            F3_LH, F3_LHU: mem_req_strb = 4'b0011 << offset;
            default:       mem_req_strb = 4'b1111;
        endcase
        if (state == AMO_WRITE) begin
            mem_req_data = amo_result;
            mem_req_strb = 4'b1111;
        end else if (is_sc) begin
            mem_req_data = rs2_val;
            mem_req_strb = sc_ok ? 4'b1111 : 4'b0000;   // failed sc leaves memory alone
        end
    end

    // lr/sc reservation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resv_vld <= 1'b0;
        end else if (inst_fire && is_lr) begin
            resv_vld <= 1'b1;
        end else if (inst_fire && is_sc) begin
            resv_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_fire && is_lr) begin
            resv_addr <= addr;
        end
    end

    // ================================================
    // pending entry payload
    // ================================================
    always_comb begin
        if (is_rmw) begin
            enq.kind = AMO_RMW;
        end else if (is_lr) begin
            enq.kind = LR;
        end else if (is_sc) begin
            enq.kind = SC_DONE;
        end else begin
            enq.kind = LOAD;
        end
    end

    assign enq.rd_idx = inst_rd_idx;
    assign enq.tag    = inst_tag;
    assign enq.wr_en  = inst_rd_en;
    assign enq.funct3 = funct3;
    assign enq.offset = offset;
    assign enq.sc_ok  = sc_ok;

endmodule

// ==== hw/lsu_pending_if.sv ====
`timescale 1ns/1ps

interface lsu_pending_if
    import lsu_isa_pkg::*;
();

    logic       vld;
    logic       rdy;
    pend_kind_t kind;
    reg_idx_t   rd_idx;
    tag_t       tag;
    logic       wr_en;    // instruction writes rd
    funct3_t    funct3;
    logic [1:0] offset;   // low address bits, byte lane of a load
    logic       sc_ok;    // sc outcome, only for SC_DONE

    modport source (
        output vld, kind, rd_idx, tag, wr_en, funct3, offset, sc_ok,
        input  rdy
    );

    modport sink (
        input  vld, kind, rd_idx, tag, wr_en, funct3, offset, sc_ok,
        output rdy
    );

endinterface

// ==== hw/lsu_pending_queue.sv ====
`timescale 1ns/1ps

module lsu_pending_queue
    import lsu_bus_pkg::*;
    import lsu_isa_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    lsu_pending_if.sink   enq,
    lsu_pending_if.source deq
);

    pend_kind_t            kind_mem   [PEND_DEPTH];
    reg_idx_t              rd_idx_mem [PEND_DEPTH];
    tag_t                  tag_mem    [PEND_DEPTH];
    logic                  wr_en_mem  [PEND_DEPTH];
    funct3_t               funct3_mem [PEND_DEPTH];
    logic [1:0]            offset_mem [PEND_DEPTH];
    logic                  sc_ok_mem  [PEND_DEPTH];
    logic [PEND_PTR_W-1:0] wr_ptr;
    logic [PEND_PTR_W-1:0] rd_ptr;
    logic [PEND_PTR_W:0]   count;
    logic                  empty;
    logic                  full;
    logic                  push;
    logic                  pop;

    assign empty = (count == '0);
    assign full  = (count == (PEND_PTR_W + 1)'(PEND_DEPTH));

    // an sc result only enters an empty queue, so no read ack can
    // land while it sits at the head
    assign enq.rdy = !full && ((enq.kind != SC_DONE) || empty);
    assign push    = enq.vld && enq.rdy;
    assign pop     = deq.vld && deq.rdy;

    always_ff @(posedge clk) begin
        if (push) begin
            kind_mem[wr_ptr]   <= enq.kind;
            rd_idx_mem[wr_ptr] <= enq.rd_idx;
            tag_mem[wr_ptr]    <= enq.tag;
            wr_en_mem[wr_ptr]  <= enq.wr_en;
            funct3_mem[wr_ptr] <= enq.funct3;
            offset_mem[wr_ptr] <= enq.offset;
            sc_ok_mem[wr_ptr]  <= enq.sc_ok;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // power-of-two depth wraps
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // head shown straight from storage
    assign deq.vld    = !empty;
    assign deq.kind   = kind_mem[rd_ptr];
    assign deq.rd_idx = rd_idx_mem[rd_ptr];
    assign deq.tag    = tag_mem[rd_ptr];
    assign deq.wr_en  = wr_en_mem[rd_ptr];
    assign deq.funct3 = funct3_mem[rd_ptr];
    assign deq.offset = offset_mem[rd_ptr];
    assign deq.sc_ok  = sc_ok_mem[rd_ptr];

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top
    import lsu_bus_pkg::*;
    import lsu_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    // instruction in
    input  logic     instruction_vld,
    output logic     instruction_rdy,
    input  inst_t    instruction_pld,
    input  tag_t     inst_tag,
    input  reg_idx_t inst_rd_idx,
    input  logic     inst_rd_en,
    input  data_t    rs1_val,
    input  data_t    rs2_val,
    input  data_t    inst_imm,

    // memory
    output logic     mem_req_vld,
    input  logic     mem_req_rdy,
    output addr_t    mem_req_addr,
    output data_t    mem_req_data,
    output strb_t    mem_req_strb,
    output logic     mem_req_opcode,
    input  logic     mem_ack_vld,
    input  data_t    mem_ack_data,

    // register file
    output logic     reg_wr_en,
    output reg_idx_t reg_index,
    output data_t    reg_val,
    output tag_t     reg_inst_tag
);

    logic  amo_old_vld;
    data_t amo_old_data;

    lsu_pending_if enq_if ();
    lsu_pending_if deq_if ();

    lsu_issue issue_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .instruction_vld (instruction_vld),
        .instruction_rdy (instruction_rdy),
        .instruction_pld (instruction_pld),
        .inst_tag        (inst_tag),
        .inst_rd_idx     (inst_rd_idx),
        .inst_rd_en      (inst_rd_en),
        .rs1_val         (rs1_val),
        .rs2_val         (rs2_val),
        .inst_imm        (inst_imm),
        .mem_req_vld     (mem_req_vld),
        .mem_req_rdy     (mem_req_rdy),
        .mem_req_addr    (mem_req_addr),
        .mem_req_data    (mem_req_data),
        .mem_req_strb    (mem_req_strb),
        .mem_req_opcode  (mem_req_opcode),
        .amo_old_vld     (amo_old_vld),
        .amo_old_data    (amo_old_data),
        .enq             (enq_if.source)
    );

    lsu_pending_queue queue_i (
        .clk   (clk),
        .rst_n (rst_n),
        .enq   (enq_if.sink),
        .deq   (deq_if.source)
    );

    lsu_writeback writeback_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .deq          (deq_if.sink),
        .mem_ack_vld  (mem_ack_vld),
        .mem_ack_data (mem_ack_data),
        .reg_wr_en    (reg_wr_en),
        .reg_index    (reg_index),
        .reg_val      (reg_val),
        .reg_inst_tag (reg_inst_tag),
        .amo_old_vld  (amo_old_vld),
        .amo_old_data (amo_old_data)
    );

endmodule

// ==== hw/lsu_writeback.sv ====
`timescale 1ns/1ps

module lsu_writeback
    import lsu_bus_pkg::*;
    import lsu_isa_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    lsu_pending_if.sink deq,

    input  logic        mem_ack_vld,
    input  data_t       mem_ack_data,

    output logic        reg_wr_en,
    output reg_idx_t    reg_index,
    output data_t       reg_val,
    output tag_t        reg_inst_tag,

    output logic        amo_old_vld,
    output data_t       amo_old_data
);

    logic  take;
    data_t shifted;
    data_t load_val;
    data_t wr_val;

    // acks arrive in request order, so the head owns each one
    assign deq.rdy = (deq.kind == SC_DONE) || mem_ack_vld;
    assign take    = deq.vld && deq.rdy;

    assign amo_old_vld  = take && (deq.kind == AMO_RMW);
    assign amo_old_data = mem_ack_data;

    // ================================================
    // load extension
    // ================================================
    assign shifted = mem_ack_data >> {deq.offset, 3'b000};

    always_comb begin
        case (deq.funct3)
            F3_LB:   load_val = {{24{shifted[7]}}, shifted[7:0]};
            F3_LBU:  load_val = {24'b0, shifted[7:0]};
            F3_LH:   load_val = {{16{shifted[15]}}, shifted[15:0]};
            F3_LHU:  load_val = {16'b0, shifted[15:0]};
            F3_LW:   load_val = mem_ack_data;
            default: load_val = mem_ack_data;
        endcase
    end

    always_comb begin
        case (deq.kind)
            LOAD:        wr_val = load_val;
            LR, AMO_RMW: wr_val = mem_ack_data;          // raw old word
            SC_DONE:     wr_val = deq.sc_ok ? 32'd0 : 32'd1;
            default:     wr_val = mem_ack_data;
        endcase
    end

    // ================================================
    // register write, one cycle after the pop
    // ================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_wr_en <= 1'b0;
        end else begin
            reg_wr_en <= take && deq.wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            reg_index    <= deq.rd_idx;
            reg_val      <= wr_val;
            reg_inst_tag <= deq.tag;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the LSU testbench with Verilator, run it, then judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f build.f --top-module tb_lsu -o tb_lsu_sim \
    && ./obj_dir/tb_lsu_sim 2>&1 | tee sim.log \
    || { echo "verilator build or run failed"; exit 1; }

grep -q "^STATUS: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== testbench/tb_lsu_model.svh ====
`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

// ================================================
// reference memory and reservation
// ================================================
localparam addr_t WIN_BASE  = 32'h0000_2000;   // 64-word test window
localparam int    WIN_WORDS = 64;

data_t    ref_mem [WIN_WORDS];
logic     resv_vld  = 1'b0;
addr_t    resv_addr = '0;
reg_idx_t exp_idx_q [$];
tag_t     exp_tag_q [$];
data_t    exp_val_q [$];
int       wr_expected = 0;

// start value of a word, mixed from the whole address
function automatic data_t fill_word(addr_t a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5c3a_96e1;
endfunction

task automatic load_fill_pattern();
    int i;
    for (i = 0; i < WIN_WORDS; i++) begin
        ref_mem[i] = fill_word(WIN_BASE + addr_t'(4 * i));
    end
endtask

function automatic data_t extend_load(data_t word, funct3_t f3, logic [1:0] off);
    logic [7:0]  b;
    logic [15:0] h;
    case (off)
        2'd0:    b = word[7:0];
        2'd1:    b = word[15:8];
        2'd2:    b = word[23:16];
        default: b = word[31:24];
    endcase
    h = off[1] ? word[31:16] : word[15:0];
    case (f3)
        F3_LB:   return {{24{b[7]}}, b};
        F3_LBU:  return {24'h0, b};
        F3_LH:   return {{16{h[15]}}, h};
        F3_LHU:  return {16'h0, h};
        default: return word;
    endcase
endfunction

// stores use the same width codes as loads
function automatic data_t merge_store(data_t word, data_t src, funct3_t f3, logic [1:0] off);
    int    size;
    int    k;
    data_t res;
    size = (f3 == F3_LB) ? 1 : ((f3 == F3_LH) ? 2 : 4);
    res  = word;
    for (k = 0; k < size; k++) begin
        res[8 * (k + int'(off)) +: 8] = src[8 * k +: 8];
    end
    return res;
endfunction

function automatic data_t amo_combine(logic [4:0] f5, data_t old, data_t src);
    case (f5)
        AMO_ADD:  return old + src;
        AMO_XOR:  return old ^ src;
        AMO_AND:  return old & src;
        AMO_OR:   return old | src;
        AMO_MIN:  return ($signed(old) <= $signed(src)) ? old : src;
        AMO_MAX:  return ($signed(old) >= $signed(src)) ? old : src;
        AMO_MINU: return (old <= src) ? old : src;
        AMO_MAXU: return (old >= src) ? old : src;
        default:  return src;   // swap
    endcase
endfunction

// one accepted instruction, in program order
task automatic predict_instruction(inst_t inst, data_t rs1, data_t rs2, data_t imm,
                                   reg_idx_t rd, tag_t tag, logic rd_en);
    addr_t      a;
    logic [5:0] w;
    data_t      old;
    data_t      result;
    logic       ok;
    logic       has_result;
    a          = rs1 + imm;
    w          = a[7:2];
    old        = ref_mem[w];
    result     = old;
    has_result = 1'b1;
    case (inst[6:2])
        OPC_LOAD:  result = extend_load(old, inst[14:12], a[1:0]);
        OPC_STORE: begin
            ref_mem[w] = merge_store(old, rs2, inst[14:12], a[1:0]);
            has_result = 1'b0;
        end
        OPC_AMO: begin
            if (inst[31:27] == AMO_LR) begin
                resv_vld  = 1'b1;
                resv_addr = a;
            end else if (inst[31:27] == AMO_SC) begin
                ok       = resv_vld && (resv_addr == a);
                resv_vld = 1'b0;   // any sc drops the reservation
                if (ok) ref_mem[w] = rs2;
                result = ok ? 32'd0 : 32'd1;
            end else begin
                ref_mem[w] = amo_combine(inst[31:27], old, rs2);
            end
        end
        default: has_result = 1'b0;
    endcase
    if (has_result && rd_en) begin
        exp_idx_q.push_back(rd);
        exp_tag_q.push_back(tag);
        exp_val_q.push_back(result);
        wr_expected++;
    end
endtask

`endif

// ==== testbench/tb_lsu.sv ====
`timescale 1ns/1ps

module tb_lsu
    import lsu_bus_pkg::*;
    import lsu_isa_pkg::*;
();

    localparam int          NUM_INSTR      = 1500;
    localparam int          TIMEOUT_CYCLES = NUM_INSTR * 12 + 200;
    localparam logic [31:0] SEED           = 32'h0bb4f84a;

    localparam funct3_t    LOAD_F3 [5] = '{F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
    localparam logic [4:0] RMW_OPS [9] = '{AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND, AMO_OR,
                                          AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU};

    logic     clk = 1'b0;
    logic     rst_n;
    logic     instruction_vld;
    logic     instruction_rdy;
    inst_t    instruction_pld;
    tag_t     inst_tag;
    reg_idx_t inst_rd_idx;
    logic     inst_rd_en;
    data_t    rs1_val;
    data_t    rs2_val;
    data_t    inst_imm;
    logic     mem_req_vld;
    logic     mem_req_rdy;
    addr_t    mem_req_addr;
    data_t    mem_req_data;
    strb_t    mem_req_strb;
    logic     mem_req_opcode;
    logic     mem_ack_vld;
    data_t    mem_ack_data;
    logic     reg_wr_en;
    reg_idx_t reg_index;
    data_t    reg_val;
    tag_t     reg_inst_tag;

    `include "tb_lsu_model.svh"

    data_t resp_mem [WIN_WORDS];   // memory behind the bus
    data_t ack_data_q [$];
    int    ack_due_q [$];
    int    last_due     = 0;
    int    cycle_cnt    = 0;
    int    wr_seen      = 0;
    addr_t last_lr_addr = '0;
    logic  have_lr      = 1'b0;

    lsu_top dut_i (.*);

    always #4 clk = ~clk;

    // ================================================
    // helpers and checks
    // ================================================
    function automatic int rand_range(int lo, int hi);
        return lo + int'($urandom % 32'(hi - lo + 1));
    endfunction

    function automatic inst_t encode_inst(logic [4:0] opc, funct3_t f3, logic [4:0] f5,
                                          reg_idx_t rd);
        return {f5, 2'b00, 5'd0, 5'd0, f3, rd, opc, 2'b11};
    endfunction

    // atomic read-modify-write, i.e. an amo that is neither lr nor sc
    function automatic logic is_amo_rmw(inst_t inst);
        return (inst[6:2] == OPC_AMO) && (inst[31:27] != AMO_LR) && (inst[31:27] != AMO_SC);
    endfunction

    task automatic abort_run(string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_data(string name, data_t exp, data_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_reg_idx(string name, reg_idx_t exp, reg_idx_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "register index mismatch");
        end
    endtask

    task automatic check_tag(string name, tag_t exp, tag_t act);
        if (exp !== act) begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("STATUS: FAIL");
            $fatal(1, "tag mismatch");
        end
    endtask

    task automatic apply_write(addr_t a, data_t d, strb_t s);
        int k;
        for (k = 0; k < 4; k++) begin
            if (s[k]) resp_mem[a[7:2]][8 * k +: 8] = d[8 * k +: 8];
        end
    endtask

    // ================================================
    // instruction driver
    // ================================================
    task automatic build_instruction(int n);
        int         sel;
        int         off;
        addr_t      a;
        funct3_t    f3;
        logic [4:0] opc;
        logic [4:0] f5;
        sel = rand_range(0, 99);
        a   = WIN_BASE + addr_t'(4 * rand_range(0, WIN_WORDS - 1));
        f3  = F3_LW;
        f5  = 5'd0;
        if (sel < 30) begin
            opc = OPC_LOAD;
            f3  = LOAD_F3[rand_range(0, 4)];
        end else if (sel < 55) begin
            opc = OPC_STORE;
            f3  = funct3_t'(rand_range(0, 2));   // sb, sh, sw
        end else if (sel < 65) begin
            opc          = OPC_AMO;
            f5           = AMO_LR;
            last_lr_addr = a;
            have_lr      = 1'b1;
        end else if (sel < 75) begin
            opc = OPC_AMO;
            f5  = AMO_SC;
            if (have_lr && rand_range(0, 9) < 6) a = last_lr_addr;   // mostly a matching sc
        end else begin
            opc = OPC_AMO;
            f5  = RMW_OPS[rand_range(0, 8)];
        end
        case (f3)
            F3_LB, F3_LBU: off = rand_range(0, 3);
            F3_LH, F3_LHU: off = 2 * rand_range(0, 1);
            default:       off = 0;
        endcase
        a               = a + addr_t'(off);
        inst_imm        = data_t'(rand_range(0, 127) - 64);
        rs1_val         = a - inst_imm;
        rs2_val         = $urandom;
        inst_rd_idx     = reg_idx_t'(rand_range(0, 31));
        inst_rd_en      = (rand_range(0, 3) != 0);
        inst_tag        = tag_t'(n);
        instruction_pld = encode_inst(opc, f3, f5, inst_rd_idx);
        instruction_vld = 1'b1;
    endtask

    // held until the handshake, an atomic ends with its write
    task automatic wait_accept();
        @(negedge clk);
        while (!instruction_rdy) @(negedge clk);
        @(posedge clk);
        #1;
        instruction_vld = 1'b0;
    endtask

    initial begin
        int n;
        int i;
        int gap;
        void'($urandom(SEED));
        rst_n           = 1'b0;
        instruction_vld = 1'b0;
        instruction_pld = '0;
        inst_tag        = '0;
        inst_rd_idx     = '0;
        inst_rd_en      = 1'b0;
        rs1_val         = '0;
        rs2_val         = '0;
        inst_imm        = '0;
        load_fill_pattern();
        for (i = 0; i < WIN_WORDS; i++) begin
            resp_mem[i] = fill_word(WIN_BASE + addr_t'(4 * i));
        end
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (n = 0; n < NUM_INSTR; n++) begin
            gap = rand_range(0, 2);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            build_instruction(n);
            wait_accept();
        end
        // let the last acks land, then count the writes
        while (ack_due_q.size() != 0) @(negedge clk);
        repeat (20) @(negedge clk);
        if (wr_seen != wr_expected) begin
            $display("FAILED write_count: expected %0d, actual %0d", wr_expected, wr_seen);
            $display("STATUS: FAIL");
            $fatal(1, "register write count mismatch");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

    // ================================================
    // memory responder
    // ================================================
    initial begin
        mem_req_rdy  = 1'b0;
        mem_ack_vld  = 1'b0;
        mem_ack_data = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n) begin
                mem_req_rdy = (rand_range(0, 3) != 0);
                if (ack_due_q.size() != 0 && ack_due_q[0] <= cycle_cnt) begin
                    mem_ack_vld  = 1'b1;
                    mem_ack_data = ack_data_q.pop_front();
                    ack_due_q.delete(0);
                end else begin
                    mem_ack_vld  = 1'b0;
                    mem_ack_data = '0;
                end
            end
        end
    end

    // sampled mid-cycle, all inputs settled
    always @(negedge clk) begin
        int due;
        if (rst_n) begin
            if (reg_wr_en) begin
                if (exp_val_q.size() == 0) begin
                    abort_run("register write seen while the model expects none");
                end else begin
                    check_reg_idx($sformatf("write %0d index", wr_seen),
                                  exp_idx_q.pop_front(), reg_index);
                    check_tag($sformatf("write %0d tag", wr_seen),
                              exp_tag_q.pop_front(), reg_inst_tag);
                    check_data($sformatf("write %0d value", wr_seen),
                               exp_val_q.pop_front(), reg_val);
                    wr_seen++;
                end
            end
            if (mem_req_vld && mem_req_rdy) begin
                if (mem_req_addr[31:8] != WIN_BASE[31:8]) begin
                    abort_run("memory request outside the test window");
                end else if (mem_req_opcode == BUS_WRITE) begin
                    apply_write(mem_req_addr, mem_req_data, mem_req_strb);
                end else begin
                    ack_data_q.push_back(resp_mem[mem_req_addr[7:2]]);
                    due = cycle_cnt + rand_range(1, 4);
                    if (due <= last_due) due = last_due + 1;   // one ack per cycle, in order
                    last_due = due;
                    ack_due_q.push_back(due);
                end
            end
            if (instruction_vld && instruction_rdy && !is_amo_rmw(instruction_pld)) begin
                predict_instruction(instruction_pld, rs1_val, rs2_val, inst_imm,
                                    inst_rd_idx, inst_tag, inst_rd_en);
            end else if (instruction_vld && is_amo_rmw(instruction_pld) && mem_req_vld
                         && mem_req_rdy && (mem_req_opcode == BUS_READ)) begin
                // an atomic writes rd before its final handshake
                predict_instruction(instruction_pld, rs1_val, rs2_val, inst_imm,
                                    inst_rd_idx, inst_tag, inst_rd_en);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles, the LSU stopped making progress",
                                cycle_cnt));
        end
    end

endmodule
